//--- hdl/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// instruction queue holds 2**IQ_DEPTH_LOG2 entries
`define IQ_DEPTH_LOG2 3
`define IQ_DEPTH      (1 << `IQ_DEPTH_LOG2)

// register numbers with a fixed role
`define REG_ZERO 5'd0
`define REG_RA   5'd31

`endif

//--- hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // ********************
    // widths with a meaning
    typedef logic [31:0] word_t;          // pc or instruction
    typedef logic [63:0] fetch_entry_t;   // {pc, inst}
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] imme_t;
    typedef logic [25:0] j_imme_t;
    typedef logic [31:0] count_t;

    // ********************
    // primary opcodes of the decoded subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // function field under OP_SPECIAL
    typedef enum logic [5:0] {
        FN_SLL   = 6'h00,
        FN_SRL   = 6'h02,
        FN_JR    = 6'h08,
        FN_JALR  = 6'h09,
        FN_MFHI  = 6'h10,
        FN_MTHI  = 6'h11,
        FN_MFLO  = 6'h12,
        FN_MTLO  = 6'h13,
        FN_MULT  = 6'h18,
        FN_MULTU = 6'h19,
        FN_DIV   = 6'h1a,
        FN_DIVU  = 6'h1b,
        FN_ADDU  = 6'h21,
        FN_SUBU  = 6'h23,
        FN_AND   = 6'h24,
        FN_OR    = 6'h25,
        FN_XOR   = 6'h26,
        FN_SLT   = 6'h2a
    } funct_t;

endpackage

`default_nettype wire

//--- hdl/inst_queue.sv
`default_nettype none

`include "cpu_macros.svh"

module inst_queue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  cpu_pkg::fetch_entry_t push_data,
    input  logic                  pop_1,
    input  logic                  pop_2,
    output cpu_pkg::fetch_entry_t head_1,
    output cpu_pkg::fetch_entry_t head_2,
    output logic                  head_1_ok,
    output logic                  head_2_ok,
    output logic                  full
);

    localparam int DEPTH = `IQ_DEPTH;

    typedef logic [`IQ_DEPTH_LOG2-1:0] ptr_t;
    typedef logic [`IQ_DEPTH_LOG2:0]   cnt_t;   // one extra bit to hold DEPTH

    cpu_pkg::fetch_entry_t mem [DEPTH];

    ptr_t       wr_ptr;
    ptr_t       rd_ptr;
    cnt_t       count;
    logic       wr_en;
    logic [1:0] pop_num;

    // a push into a full queue is dropped
    assign wr_en   = push && !full;
    assign pop_num = pop_1 ? (pop_2 ? 2'd2 : 2'd1) : 2'd0;

    // ********************
    // storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // ********************
    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            rd_ptr <= rd_ptr + ptr_t'(pop_num);   // wraps with the buffer
            count  <= count + cnt_t'(wr_en) - cnt_t'(pop_num);
        end
    end

    // two oldest entries
    assign head_1 = mem[rd_ptr];
    assign head_2 = mem[rd_ptr + ptr_t'(1)];

    assign head_1_ok = (count != '0);
    assign head_2_ok = (count >= cnt_t'(2));
    assign full      = (count == cnt_t'(DEPTH));

endmodule

`default_nettype wire

//--- hdl/idu_1.sv
`default_nettype none

`include "cpu_macros.svh"

module idu_1 (
    input  cpu_pkg::word_t     inst,
    output cpu_pkg::reg_addr_t rs,
    output cpu_pkg::reg_addr_t rt,
    output cpu_pkg::reg_addr_t rd,
    output cpu_pkg::reg_addr_t sa,
    output cpu_pkg::reg_addr_t w_reg_dst,
    output cpu_pkg::imme_t     imme,
    output cpu_pkg::j_imme_t   j_imme,
    output logic               w_reg_ena,
    output logic               is_branch,
    output logic               is_j_imme,
    output logic               is_jr,
    output logic               is_ls,
    output logic               is_hilo
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];

    // raw fields
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign sa     = inst[10:6];
    assign imme   = inst[15:0];
    assign j_imme = inst[25:0];

    always_comb begin
        w_reg_ena = 1'b0;
        w_reg_dst = `REG_ZERO;
        is_branch = 1'b0;
        is_j_imme = 1'b0;
        is_jr     = 1'b0;
        is_ls     = 1'b0;
        is_hilo   = 1'b0;

        case (opcode)
            // ********************
            // R-type
            cpu_pkg::OP_SPECIAL: begin
                w_reg_dst = rd;
                case (funct)
                    cpu_pkg::FN_ADDU,
                    cpu_pkg::FN_SUBU,
                    cpu_pkg::FN_AND,
                    cpu_pkg::FN_OR,
                    cpu_pkg::FN_XOR,
                    cpu_pkg::FN_SLT,
                    cpu_pkg::FN_SLL,
                    cpu_pkg::FN_SRL: w_reg_ena = 1'b1;
                    cpu_pkg::FN_JR: is_jr = 1'b1;
                    cpu_pkg::FN_JALR: begin
                        is_jr     = 1'b1;
                        w_reg_ena = 1'b1;   // link goes to rd
                    end
                    cpu_pkg::FN_MFHI,
                    cpu_pkg::FN_MFLO: begin
                        is_hilo   = 1'b1;
                        w_reg_ena = 1'b1;
                    end
                    cpu_pkg::FN_MTHI,
                    cpu_pkg::FN_MTLO,
                    cpu_pkg::FN_MULT,
                    cpu_pkg::FN_MULTU,
                    cpu_pkg::FN_DIV,
                    cpu_pkg::FN_DIVU: is_hilo = 1'b1;
                    default: begin
                    end
                endcase
            end

            // ********************
            // I-type
            cpu_pkg::OP_ADDIU,
            cpu_pkg::OP_ANDI,
            cpu_pkg::OP_ORI,
            cpu_pkg::OP_LUI: begin
                w_reg_ena = 1'b1;
                w_reg_dst = rt;
            end
            cpu_pkg::OP_LW: begin
                is_ls     = 1'b1;
                w_reg_ena = 1'b1;
                w_reg_dst = rt;
            end
            cpu_pkg::OP_SW:  is_ls     = 1'b1;   // no register write
            cpu_pkg::OP_BEQ,
            cpu_pkg::OP_BNE: is_branch = 1'b1;

            // ********************
            // J-type
            cpu_pkg::OP_J:   is_j_imme = 1'b1;
            cpu_pkg::OP_JAL: begin
                is_j_imme = 1'b1;
                w_reg_ena = 1'b1;
                w_reg_dst = `REG_RA;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/issue.sv
`default_nettype none

`include "cpu_macros.svh"

module issue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  head_1_ok,
    input  logic                  head_2_ok,
    input  cpu_pkg::fetch_entry_t head_1,
    input  cpu_pkg::fetch_entry_t head_2,
    output logic                  pop_1,
    output logic                  pop_2,

    // slot 1
    output logic                  valid_1,
    output cpu_pkg::word_t        pc_1,
    output cpu_pkg::word_t        inst_1,
    output cpu_pkg::reg_addr_t    rs_1,
    output cpu_pkg::reg_addr_t    rt_1,
    output cpu_pkg::reg_addr_t    rd_1,
    output cpu_pkg::reg_addr_t    sa_1,
    output logic                  w_reg_ena_1,
    output cpu_pkg::reg_addr_t    w_reg_dst_1,
    output cpu_pkg::imme_t        imme_1,
    output cpu_pkg::j_imme_t      j_imme_1,
    output logic                  is_branch_1,
    output logic                  is_j_imme_1,
    output logic                  is_jr_1,
    output logic                  is_ls_1,

    // slot 2
    output logic                  valid_2,
    output cpu_pkg::word_t        pc_2,
    output cpu_pkg::word_t        inst_2,
    output cpu_pkg::reg_addr_t    rs_2,
    output cpu_pkg::reg_addr_t    rt_2,
    output cpu_pkg::reg_addr_t    rd_2,
    output cpu_pkg::reg_addr_t    sa_2,
    output logic                  w_reg_ena_2,
    output cpu_pkg::reg_addr_t    w_reg_dst_2,
    output cpu_pkg::imme_t        imme_2,
    output cpu_pkg::j_imme_t      j_imme_2,
    output logic                  is_branch_2,
    output logic                  is_j_imme_2,
    output logic                  is_jr_2,
    output logic                  is_ls_2,

    output cpu_pkg::count_t       issue_count,
    output cpu_pkg::count_t       pair_count
);

    logic is_hilo_1;
    logic jmp_1;
    logic jmp_2;
    logic raw_hazard;

    assign pc_1   = head_1[63:32];
    assign inst_1 = head_1[31:0];
    assign pc_2   = head_2[63:32];
    assign inst_2 = head_2[31:0];

    idu_1 dec_1 (
        .inst      (inst_1),
        .rs        (rs_1),
        .rt        (rt_1),
        .rd        (rd_1),
        .sa        (sa_1),
        .w_reg_dst (w_reg_dst_1),
        .imme      (imme_1),
        .j_imme    (j_imme_1),
        .w_reg_ena (w_reg_ena_1),
        .is_branch (is_branch_1),
        .is_j_imme (is_j_imme_1),
        .is_jr     (is_jr_1),
        .is_ls     (is_ls_1),
        .is_hilo   (is_hilo_1)
    );

    idu_1 dec_2 (
        .inst      (inst_2),
        .rs        (rs_2),
        .rt        (rt_2),
        .rd        (rd_2),
        .sa        (sa_2),
        .w_reg_dst (w_reg_dst_2),
        .imme      (imme_2),
        .j_imme    (j_imme_2),
        .w_reg_ena (w_reg_ena_2),
        .is_branch (is_branch_2),
        .is_j_imme (is_j_imme_2),
        .is_jr     (is_jr_2),
        .is_ls     (is_ls_2),
        .is_hilo   ()             // slot 2 hi/lo never splits a pair
    );

    // ********************
    // pairing
    assign jmp_1 = is_branch_1 | is_j_imme_1 | is_jr_1;
    assign jmp_2 = is_branch_2 | is_j_imme_2 | is_jr_2;

    // slot 2 reads what slot 1 writes, register 0 excluded
    assign raw_hazard = w_reg_ena_1 && (w_reg_dst_1 != `REG_ZERO)
                     && ((w_reg_dst_1 == rs_2) || (w_reg_dst_1 == rt_2));

    always_comb begin
        valid_1 = 1'b0;
        valid_2 = 1'b0;
        if (!stall && head_1_ok) begin
            valid_1 = 1'b1;
            if (jmp_1) begin
                valid_2 = head_2_ok;            // keep delay slot with its jump
            end else if (head_2_ok && raw_hazard) begin
                valid_2 = 1'b0;
            end else if (is_ls_1 || jmp_2 || is_hilo_1) begin
                valid_2 = 1'b0;
            end else begin
                valid_2 = head_2_ok;
            end
        end
    end

    assign pop_1 = valid_1;
    assign pop_2 = valid_2;

    // ********************
    // performance counters
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_count <= '0;
            pair_count  <= '0;
        end else begin
            issue_count <= issue_count + cpu_pkg::count_t'(valid_1)
                                       + cpu_pkg::count_t'(valid_2);
            if (valid_1 && valid_2) begin
                pair_count <= pair_count + cpu_pkg::count_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/front_end.sv
`default_nettype none

module front_end (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  cpu_pkg::fetch_entry_t push_data,
    input  logic                  stall,
    output logic                  full,

    output logic                  valid_1,
    output cpu_pkg::word_t        pc_1,
    output cpu_pkg::word_t        inst_1,
    output cpu_pkg::reg_addr_t    rs_1,
    output cpu_pkg::reg_addr_t    rt_1,
    output cpu_pkg::reg_addr_t    rd_1,
    output cpu_pkg::reg_addr_t    sa_1,
    output logic                  w_reg_ena_1,
    output cpu_pkg::reg_addr_t    w_reg_dst_1,
    output cpu_pkg::imme_t        imme_1,
    output cpu_pkg::j_imme_t      j_imme_1,
    output logic                  is_branch_1,
    output logic                  is_j_imme_1,
    output logic                  is_jr_1,
    output logic                  is_ls_1,

    output logic                  valid_2,
    output cpu_pkg::word_t        pc_2,
    output cpu_pkg::word_t        inst_2,
    output cpu_pkg::reg_addr_t    rs_2,
    output cpu_pkg::reg_addr_t    rt_2,
    output cpu_pkg::reg_addr_t    rd_2,
    output cpu_pkg::reg_addr_t    sa_2,
    output logic                  w_reg_ena_2,
    output cpu_pkg::reg_addr_t    w_reg_dst_2,
    output cpu_pkg::imme_t        imme_2,
    output cpu_pkg::j_imme_t      j_imme_2,
    output logic                  is_branch_2,
    output logic                  is_j_imme_2,
    output logic                  is_jr_2,
    output logic                  is_ls_2,

    output cpu_pkg::count_t       issue_count,
    output cpu_pkg::count_t       pair_count
);

    // queue to issue
    cpu_pkg::fetch_entry_t head_1;
    cpu_pkg::fetch_entry_t head_2;
    logic                  head_1_ok;
    logic                  head_2_ok;
    logic                  pop_1;
    logic                  pop_2;

    // port names line up on both sides
    inst_queue iq (.*);

    issue isu (.*);

endmodule

`default_nettype wire

//--- verification/front_end_assert.sv
`default_nettype none

module front_end_assert (
    input logic clk,
    input logic rst,
    input logic push,
    input logic full,
    input logic pop_1,
    input logic pop_2,
    input logic stall,
    input logic valid_1,
    input logic valid_2
);
    timeunit 1ns;
    timeprecision 100ps;

    pop_pair_order: assert property (@(posedge clk) disable iff (rst) pop_2 |-> pop_1)
        else $error("pop_2 raised without pop_1");

    push_not_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("push while the queue is full");

    stall_blocks_pop: assert property (@(posedge clk) disable iff (rst)
                                       stall |-> !(pop_1 || pop_2))
        else $error("pop while stall is high");

    // the queue is empty once reset has been seen
    idle_after_reset: assert property (@(posedge clk) rst |=> !(valid_1 || valid_2))
        else $error("valid high in the cycle after reset");

endmodule

bind inst_queue front_end_assert iq_chk (
    .clk(clk), .rst(rst), .push(push), .full(full), .pop_1(pop_1), .pop_2(pop_2),
    .stall(1'b0), .valid_1(1'b0), .valid_2(1'b0)
);

bind issue front_end_assert isu_chk (
    .clk(clk), .rst(rst), .push(1'b0), .full(1'b0), .pop_1(pop_1), .pop_2(pop_2),
    .stall(stall), .valid_1(valid_1), .valid_2(valid_2)
);

`default_nettype wire

//--- verification/front_end_tb.sv
`default_nettype none

`include "cpu_macros.svh"

module front_end_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH       = `IQ_DEPTH;
    localparam int CYCLE_LIMIT = 2000;   // six short programs, each far below 100 cycles

    logic clk = 1'b0;
    logic rst, push, stall, full;
    cpu_pkg::fetch_entry_t push_data;
    logic valid_1, w_reg_ena_1, is_branch_1, is_j_imme_1, is_jr_1, is_ls_1;
    logic valid_2, w_reg_ena_2, is_branch_2, is_j_imme_2, is_jr_2, is_ls_2;
    cpu_pkg::word_t pc_1, inst_1, pc_2, inst_2;
    cpu_pkg::reg_addr_t rs_1, rt_1, rd_1, sa_1, w_reg_dst_1;
    cpu_pkg::reg_addr_t rs_2, rt_2, rd_2, sa_2, w_reg_dst_2;
    cpu_pkg::imme_t imme_1, imme_2;
    cpu_pkg::j_imme_t j_imme_1, j_imme_2;
    cpu_pkg::count_t issue_count, pair_count;

    front_end dut (.*);

    cpu_pkg::fetch_entry_t model_q [$];   // entries the DUT queue should hold
    cpu_pkg::word_t prog [$];
    cpu_pkg::word_t pc_next = 32'hbfc0_0000;
    logic [31:0] lfsr = 32'h56c3e270;
    int errors = 0;
    int cycles = 0;
    int exp_issue = 0;
    int exp_pair = 0;

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped by timeout after %0d cycles, %0d errors", cycles, errors);
            $display("Test failures found");
            $finish;
        end
    end

    // ********************
    // instruction encoders and random operands
    function automatic cpu_pkg::word_t enc_r(logic [5:0] fn, logic [4:0] rs, rt, rd);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic cpu_pkg::word_t enc_i(logic [5:0] op, logic [4:0] rs, rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic cpu_pkg::word_t enc_j(logic [5:0] op, logic [25:0] target);
        return {op, target};
    endfunction

    function automatic logic [4:0] lfsr_bits(int n);
        logic [4:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r    = {r[3:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // reads r0..r15 and writes r16..r31
    function automatic cpu_pkg::word_t random_alu();
        logic [4:0] a;
        logic [4:0] b;
        logic [4:0] d;
        a = lfsr_bits(4);
        b = lfsr_bits(4);
        d = 5'h10 | lfsr_bits(4);
        if (lfsr_bits(1) == 5'd1)
            return enc_r(cpu_pkg::FN_ADDU, a, b, d);
        return enc_i(cpu_pkg::OP_ADDIU, a, d, {11'd0, b});
    endfunction

    // ********************
    // reference models
    // {w_reg_ena, w_reg_dst, is_branch, is_j_imme, is_jr, is_ls, is_hilo}
    function automatic logic [10:0] decode_model(cpu_pkg::word_t i);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [10:0] d;
        op = i[31:26];
        fn = i[5:0];
        d  = '0;
        if (op == 6'h00) begin
            d[10]  = fn inside {6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a,
                                6'h00, 6'h02, 6'h09, 6'h10, 6'h12};
            d[9:5] = i[15:11];
            d[2]   = fn inside {6'h08, 6'h09};
            d[0]   = fn inside {[6'h10:6'h13], [6'h18:6'h1b]};
        end else begin
            d[10]  = op inside {6'h09, 6'h0c, 6'h0d, 6'h0f, 6'h23, 6'h03};
            d[9:5] = (op == 6'h03) ? 5'd31 : i[20:16];   // jal links r31
            d[4]   = op inside {6'h04, 6'h05};
            d[3]   = op inside {6'h02, 6'h03};
            d[1]   = op inside {6'h23, 6'h2b};
        end
        return d;
    endfunction

    // may the second head go along with the first
    function automatic logic pair_model(cpu_pkg::word_t a, cpu_pkg::word_t b);
        logic [10:0] da;
        logic [10:0] db;
        da = decode_model(a);
        db = decode_model(b);
        if (|da[4:2])
            return 1'b1;
        if (da[10] && da[9:5] != 5'd0 && (da[9:5] == b[25:21] || da[9:5] == b[20:16]))
            return 1'b0;
        return !(da[1] || (|db[4:2]) || da[0]);
    endfunction

    // ********************
    // checks and stepping
    task automatic compare_value(string name, logic [31:0] got, logic [31:0] want);
        assert (got === want) else begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_slot(int n, cpu_pkg::fetch_entry_t e);
        logic [10:0] d;
        d = decode_model(e[31:0]);
        compare_value($sformatf("pc_%0d", n), n == 1 ? pc_1 : pc_2, e[63:32]);
        compare_value($sformatf("inst_%0d", n), n == 1 ? inst_1 : inst_2, e[31:0]);
        compare_value($sformatf("rs_%0d", n), n == 1 ? rs_1 : rs_2, e[25:21]);
        compare_value($sformatf("rt_%0d", n), n == 1 ? rt_1 : rt_2, e[20:16]);
        compare_value($sformatf("rd_%0d", n), n == 1 ? rd_1 : rd_2, e[15:11]);
        compare_value($sformatf("sa_%0d", n), n == 1 ? sa_1 : sa_2, e[10:6]);
        compare_value($sformatf("imme_%0d", n), n == 1 ? imme_1 : imme_2, e[15:0]);
        compare_value($sformatf("j_imme_%0d", n), n == 1 ? j_imme_1 : j_imme_2, e[25:0]);
        compare_value($sformatf("w_reg_ena_%0d", n), n == 1 ? w_reg_ena_1 : w_reg_ena_2, d[10]);
        if (d[10])
            compare_value($sformatf("w_reg_dst_%0d", n),
                          n == 1 ? w_reg_dst_1 : w_reg_dst_2, d[9:5]);
        compare_value($sformatf("{is_branch,is_j_imme,is_jr,is_ls}_%0d", n),
                      n == 1 ? {is_branch_1, is_j_imme_1, is_jr_1, is_ls_1}
                             : {is_branch_2, is_j_imme_2, is_jr_2, is_ls_2}, d[4:1]);
    endtask

    // check one cycle at mid period, then retire what issued at the edge
    task automatic step_cycle();
        logic e1;
        logic e2;
        @(negedge clk);
        e1 = !stall && model_q.size() >= 1;
        e2 = e1 && model_q.size() >= 2 && pair_model(model_q[0][31:0], model_q[1][31:0]);
        compare_value("valid_1", valid_1, e1);
        compare_value("valid_2", valid_2, e2);
        compare_value("full", full, model_q.size() == DEPTH);
        if (e1)
            check_slot(1, model_q[0]);
        if (e2)
            check_slot(2, model_q[1]);
        @(posedge clk);
        exp_issue += int'(e1) + int'(e2);
        exp_pair  += int'(e2);
        repeat (int'(e1) + int'(e2)) void'(model_q.pop_front());
    endtask

    // push prog while stalled, hold, then drain and compare the counters
    task automatic run_program(int hold);
        foreach (prog[k]) begin
            @(posedge clk);
            push      <= 1'b1;
            push_data <= {pc_next, prog[k]};
            if (model_q.size() < DEPTH)
                model_q.push_back({pc_next, prog[k]});
            pc_next += 32'd4;
        end
        @(posedge clk);
        push <= 1'b0;
        prog.delete();
        repeat (hold) step_cycle();
        stall <= 1'b0;
        while (model_q.size() != 0) step_cycle();
        stall <= 1'b1;
        @(negedge clk);
        compare_value("issue_count", issue_count, exp_issue);
        compare_value("pair_count", pair_count, exp_pair);
    endtask

    // ********************
    // directed tests
    task automatic reset_state();
        @(negedge clk);
        compare_value("valid_1", valid_1, 0);
        compare_value("valid_2", valid_2, 0);
        compare_value("full", full, 0);
        compare_value("issue_count", issue_count, 0);
        compare_value("pair_count", pair_count, 0);
        @(posedge clk);
        stall <= 1'b1;   // hold issue while the programs load
    endtask

    task automatic dependency_split();
        prog.push_back(enc_r(cpu_pkg::FN_ADDU, 1, 2, 5));
        prog.push_back(enc_r(cpu_pkg::FN_SUBU, 5, 3, 6));     // reads r5
        prog.push_back(enc_r(cpu_pkg::FN_OR, 1, 2, 10));
        prog.push_back(enc_r(cpu_pkg::FN_XOR, 1, 2, 0));      // r0 target
        prog.push_back(enc_r(cpu_pkg::FN_SLT, 0, 0, 9));
        prog.push_back(enc_i(cpu_pkg::OP_ORI, 4, 12, 16'h00ff));
        prog.push_back(enc_r(cpu_pkg::FN_AND, 12, 1, 13));
        run_program(0);
    endtask

    task automatic jump_pairing();
        prog.push_back(enc_i(cpu_pkg::OP_ADDIU, 0, 7, 16'd1));
        prog.push_back(enc_i(cpu_pkg::OP_BEQ, 8, 9, 16'd4));
        prog.push_back(enc_r(cpu_pkg::FN_ADDU, 8, 8, 10));    // delay slot
        prog.push_back(enc_j(cpu_pkg::OP_JAL, 26'h100));
        prog.push_back(enc_r(cpu_pkg::FN_ADDU, 31, 4, 11));   // reads the link
        prog.push_back(enc_i(cpu_pkg::OP_LW, 8, 12, 16'd0));
        prog.push_back(enc_r(cpu_pkg::FN_ADDU, 1, 2, 13));
        prog.push_back(enc_i(cpu_pkg::OP_SW, 8, 13, 16'd4));
        run_program(1);
        prog.push_back(enc_r(cpu_pkg::FN_MULT, 1, 2, 0));
        prog.push_back(enc_r(cpu_pkg::FN_MFLO, 0, 0, 15));
        prog.push_back(enc_r(cpu_pkg::FN_JR, 31, 0, 0));
        prog.push_back(enc_r(cpu_pkg::FN_OR, 1, 2, 14));
        prog.push_back(enc_j(cpu_pkg::OP_J, 26'h40));
        prog.push_back(enc_r(cpu_pkg::FN_SLL, 0, 2, 16));
        prog.push_back(enc_i(cpu_pkg::OP_SW, 3, 2, 16'd8));
        prog.push_back(enc_r(cpu_pkg::FN_ADDU, 1, 2, 17));
        run_program(1);
    endtask

    initial begin
        rst       = 1'b1;
        push      = 1'b0;
        push_data = '0;
        stall     = 1'b0;   // an empty queue alone keeps the valids low
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        reset_state();
        repeat (6) prog.push_back(random_alu());
        run_program(2);
        dependency_split();
        jump_pairing();
        repeat (5) prog.push_back(random_alu());      // odd count leaves a single tail
        run_program(3);
        repeat (DEPTH) prog.push_back(random_alu());
        run_program(2);
        $display("checks finished with %0d errors", errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/inst_queue.sv
hdl/idu_1.sv
hdl/issue.sv
hdl/front_end.sv
verification/front_end_assert.sv
verification/front_end_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert --timing -Wno-fatal --top-module front_end_tb -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vfront_end_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" "$log"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
